/* msx_consts.svh */
// MSX bus glue constants
`ifndef MSX_CONSTS_SVH
`define MSX_CONSTS_SVH

// ----------------------------------------------------------------------
// I/O ports and memory-mapped registers
// ----------------------------------------------------------------------
`define MSX_PORT_PSLOT			8'hA8		// Primary slot register
`define MSX_PORT_MAPPER_BASE	8'hFC		// Mapper segments FCh-FFh
`define MSX_EXPSLOT_ADDR		16'hFFFF	// Expansion slot register

// Mapper segments after reset, page 0 to page 3
`define MSX_MAPPER_RESET_0		8'd3
`define MSX_MAPPER_RESET_1		8'd2
`define MSX_MAPPER_RESET_2		8'd1
`define MSX_MAPPER_RESET_3		8'd0

// ----------------------------------------------------------------------
// SDRAM region bases, ORed with the in-region offset
// ----------------------------------------------------------------------
`define MSX_SDRAM_MAPPER_BASE		23'h40_0000	// Upper 4MB, 256 segments of 16KB
`define MSX_SDRAM_ROM_BASE_MAIN		23'h02_0000	// 32KB, slot 0-0
`define MSX_SDRAM_ROM_BASE_KANJI	23'h02_8000	// Kanji BASIC, slot 3-1
`define MSX_SDRAM_ROM_BASE_BASICN	23'h03_0000	// BASIC'N, slot 0-1
`define MSX_SDRAM_ROM_BASE_MUSIC	23'h03_4000	// MSX-MUSIC, slot 0-2
`define MSX_SDRAM_ROM_BASE_LOGO		23'h03_8000	// Logo and ext BASIC, slot 0-3
`define MSX_SDRAM_ROM_BASE_SUB		23'h04_0000	// Sub-ROM, slot 3-1 page 0
`define MSX_SDRAM_ROM_BASE_NEXTOR	23'h00_0000	// Nextor banks 0-7, slot 3-2

`endif

/* msx_pkg.sv */
// MSX bus glue types
`default_nettype none

package msx_pkg;

	typedef logic	[1:0]	slot_t;			// Slot or sub-slot number
	typedef logic	[1:0]	page_t;			// 16KB page, address bits 15:14
	typedef logic	[7:0]	segment_t;		// Mapper segment number
	typedef logic	[22:0]	sdram_addr_t;	// SDRAM byte address

	// Layout of A8h and FFFFh, page 3 in the top bits
	typedef struct packed {
		slot_t	page3;
		slot_t	page2;
		slot_t	page1;
		slot_t	page0;
	} slot_map_t;

	// ------------------------------------------------------------------
	// Pick the slot field of one page out of a slot register
	// ------------------------------------------------------------------
	function automatic slot_t slot_of_page(
		input slot_map_t	map,
		input page_t		page
	);
		case (page)
			2'd0:		return map.page0;
			2'd1:		return map.page1;
			2'd2:		return map.page2;
			default:	return map.page3;
		endcase
	endfunction

endpackage

`default_nettype wire

/* cpu_bus_if.sv */
// Z80 CPU bus bundle
`default_nettype none

interface cpu_bus_if;

	logic	[15:0]	address;	// Full 16-bit address, I/O uses the low byte
	logic	[7:0]	wdata;		// CPU write data
	logic			mreq_n;		// Memory request
	logic			iorq_n;		// I/O request
	logic			rd_n;
	logic			wr_n;

	// Decoders only observe the bus
	modport target (
		input	address,
		input	wdata,
		input	mreq_n,
		input	iorq_n,
		input	rd_n,
		input	wr_n
	);

endinterface

`default_nettype wire

/* primary_slot.sv */
// Primary slot register
`default_nettype none
`include "msx_consts.svh"

module primary_slot import msx_pkg::*; (
	input	wire			clk42m,
	input	wire			ff_reset_n,
	cpu_bus_if.target		bus,
	output	slot_map_t		pslot_map,		// Whole A8h register
	output	slot_t			pslot_cur,		// Primary slot of addressed page
	output	slot_t			page3_slot,		// For the FFFFh selects
	output	logic	[7:0]	rdata,
	output	logic			rdata_en
);
	slot_map_t		ff_pslot;
	logic			w_sel;
	page_t			w_page;

	// I/O port A8h only, no mirrors
	assign w_sel	= !bus.iorq_n && (bus.address[7:0] == `MSX_PORT_PSLOT);
	assign w_page	= bus.address[15:14];

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_pslot <= '0;						// All pages in slot 0
		end
		else if (w_sel && !bus.wr_n) begin
			ff_pslot <= bus.wdata;				// Same value every cycle of a held write
		end
	end

	// ------------------------------------------------------------------
	// Slot outputs
	// ------------------------------------------------------------------
	assign pslot_map	= ff_pslot;
	assign pslot_cur	= slot_of_page(ff_pslot, w_page);
	assign page3_slot	= ff_pslot.page3;

	// Read back
	assign rdata		= ff_pslot;
	assign rdata_en		= w_sel && !bus.rd_n;

endmodule

`default_nettype wire

/* secondary_slot.sv */
// Expansion slot register
`default_nettype none
`include "msx_consts.svh"

module secondary_slot import msx_pkg::*; (
	input	wire			clk42m,
	input	wire			ff_reset_n,
	cpu_bus_if.target		bus,
	input	wire	slot_t	own_slot,		// Primary slot being expanded
	input	wire	slot_t	pslot_cur,		// Primary slot of addressed page
	input	wire	slot_t	page3_slot,		// Primary slot of page 3
	output	slot_t			sub_cur,		// Sub-slot of addressed page
	output	logic	[7:0]	rdata,
	output	logic			rdata_en
);
	slot_map_t		ff_expslot;
	logic			w_sel;
	logic			w_own;
	page_t			w_page;

	assign w_page	= bus.address[15:14];

	// ------------------------------------------------------------------
	// Register select
	// ------------------------------------------------------------------
	// FFFFh belongs to whatever slot page 3 is in, so the register only
	// answers when that is this slot
	assign w_sel	= !bus.mreq_n &&
					  (bus.address == `MSX_EXPSLOT_ADDR) &&
					  (page3_slot == own_slot);

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_expslot <= '0;					// Sub-slot 0 on every page
		end
		else if (w_sel && !bus.wr_n) begin
			ff_expslot <= bus.wdata;
		end
	end

	// ------------------------------------------------------------------
	// Sub-slot select
	// ------------------------------------------------------------------
	assign w_own	= (pslot_cur == own_slot);	// Access lands in this slot

	always_comb begin
		if (w_own) begin
			sub_cur = slot_of_page(ff_expslot, w_page);
		end
		else begin
			sub_cur = 2'd0;						// Not ours, value unused downstream
		end
	end

	// Read back is inverted, as on real machines
	assign rdata	= ~ff_expslot;
	assign rdata_en	= w_sel && !bus.rd_n;

endmodule

`default_nettype wire

/* memory_mapper.sv */
// Memory mapper segment registers
`default_nettype none
`include "msx_consts.svh"

module memory_mapper import msx_pkg::*; (
	input	wire			clk42m,
	input	wire			ff_reset_n,
	cpu_bus_if.target		bus,
	output	segment_t		segment,		// Segment of addressed page
	output	logic	[7:0]	rdata,
	output	logic			rdata_en
);
	segment_t	[3:0]	ff_segment;			// One per page
	logic				w_sel;
	page_t				w_reg;				// Register picked by port
	page_t				w_page;				// Page picked by memory address

	// ------------------------------------------------------------------
	// Port decode, FCh to FFh
	// ------------------------------------------------------------------
	assign w_sel	= !bus.iorq_n && ({bus.address[7:2], 2'b00} == `MSX_PORT_MAPPER_BASE);
	assign w_reg	= bus.address[1:0];
	assign w_page	= bus.address[15:14];

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_segment[0] <= `MSX_MAPPER_RESET_0;
			ff_segment[1] <= `MSX_MAPPER_RESET_1;
			ff_segment[2] <= `MSX_MAPPER_RESET_2;
			ff_segment[3] <= `MSX_MAPPER_RESET_3;
		end
		else if (w_sel && !bus.wr_n) begin
			ff_segment[w_reg] <= bus.wdata;	// Full 8 bits, 4MB of mapper RAM
		end
	end

	// Segment for the SDRAM address
	assign segment	= ff_segment[w_page];

	// Read back, no unused-bit masking
	assign rdata	= ff_segment[w_reg];
	assign rdata_en	= w_sel && !bus.rd_n;

endmodule

`default_nettype wire

/* sdram_address_map.sv */
// Slot to SDRAM address map
`default_nettype none
`include "msx_consts.svh"

module sdram_address_map import msx_pkg::*; (
	cpu_bus_if.target		bus,
	input	wire	slot_t		pslot_cur,
	input	wire	slot_t		sub0,			// Sub-slot when in slot 0
	input	wire	slot_t		sub3,			// Sub-slot when in slot 3
	input	wire	segment_t	segment,
	output	sdram_addr_t		sdram_address,
	output	logic				sdram_mreq_n,
	output	logic				sdram_rd_n,
	output	logic				sdram_wr_n
);
	page_t			w_page;
	logic			w_rom_hit;		// Read-only region present
	logic			w_ram_hit;		// Mapper RAM
	sdram_addr_t	w_address;

	assign w_page = bus.address[15:14];

	// ------------------------------------------------------------------
	// Region table
	// ------------------------------------------------------------------
	always_comb begin
		w_address	= {10'd0, bus.address[12:0]};		// Unmapped default
		w_rom_hit	= 1'b0;
		w_ram_hit	= 1'b0;
		case (pslot_cur)
			2'd0: begin
				case (sub0)
					2'd0: begin						// Main ROM, pages 0-1
						w_address	= `MSX_SDRAM_ROM_BASE_MAIN | {8'd0, bus.address[14:0]};
						w_rom_hit	= !w_page[1];
					end
					2'd1: begin						// BASIC'N, page 1
						w_address	= `MSX_SDRAM_ROM_BASE_BASICN | {9'd0, bus.address[13:0]};
						w_rom_hit	= (w_page == 2'd1);
					end
					2'd2: begin						// MSX-MUSIC, page 1
						w_address	= `MSX_SDRAM_ROM_BASE_MUSIC | {9'd0, bus.address[13:0]};
						w_rom_hit	= (w_page == 2'd1);
					end
					default: begin					// Logo and ext BASIC, pages 1-2
						w_address	= `MSX_SDRAM_ROM_BASE_LOGO | {8'd0, bus.address[14:0]};
						w_rom_hit	= (w_page == 2'd1) || (w_page == 2'd2);
					end
				endcase
			end
			2'd3: begin
				case (sub3)
					2'd0: begin						// Mapper RAM, all pages
						w_address	= `MSX_SDRAM_MAPPER_BASE |
									  {1'b0, segment, bus.address[13:0]};
						w_ram_hit	= 1'b1;
					end
					2'd1: begin
						if (w_page == 2'd0) begin	// Sub-ROM
							w_address	= `MSX_SDRAM_ROM_BASE_SUB |
										  {9'd0, bus.address[13:0]};
						end
						else begin					// Kanji BASIC, pages 2 and 3 alias
							w_address	= `MSX_SDRAM_ROM_BASE_KANJI |
										  {8'd0, bus.address[15], bus.address[13:0]};
						end
						w_rom_hit	= 1'b1;
					end
					2'd2: begin						// Nextor banks, pages 1-2
						w_address	= `MSX_SDRAM_ROM_BASE_NEXTOR | {7'd0, bus.address[15:0]};
						w_rom_hit	= (w_page == 2'd1) || (w_page == 2'd2);
					end
					default: ;						// 3-3 empty
				endcase
			end
			default: ;								// Slots 1 and 2 empty
		endcase
	end

	// ------------------------------------------------------------------
	// Strobes
	// ------------------------------------------------------------------
	assign sdram_address	= w_address;
	assign sdram_mreq_n		= bus.mreq_n;
	assign sdram_rd_n		= !(!bus.mreq_n && !bus.rd_n && bus.wr_n && (w_rom_hit || w_ram_hit));
	assign sdram_wr_n		= !(!bus.mreq_n && !bus.wr_n && w_ram_hit);	// ROM writes dropped

endmodule

`default_nettype wire

/* msx_bus_glue.sv */
// MSX slot and memory map glue
`default_nettype none

module msx_bus_glue import msx_pkg::*; (
	input	wire			clk42m,
	input	wire			ff_reset_n,
	input	wire	[15:0]	address,
	input	wire	[7:0]	wdata,
	input	wire			mreq_n,
	input	wire			iorq_n,
	input	wire			rd_n,
	input	wire			wr_n,
	output	logic	[7:0]	rdata,
	output	sdram_addr_t	sdram_address,
	output	logic			sdram_mreq_n,
	output	logic			sdram_rd_n,
	output	logic			sdram_wr_n
);
	slot_t			w_pslot_cur;
	slot_t			w_page3_slot;
	slot_t			w_sub0;
	slot_t			w_sub3;
	segment_t		w_segment;
	logic	[7:0]	w_pslot_q;
	logic			w_pslot_q_en;
	logic	[7:0]	w_exp0_q;
	logic			w_exp0_q_en;
	logic	[7:0]	w_exp3_q;
	logic			w_exp3_q_en;
	logic	[7:0]	w_mapper_q;
	logic			w_mapper_q_en;
	logic	[7:0]	ff_rdata;

	// ------------------------------------------------------------------
	// CPU bus
	// ------------------------------------------------------------------
	cpu_bus_if bus ();

	assign bus.address	= address;
	assign bus.wdata	= wdata;
	assign bus.mreq_n	= mreq_n;
	assign bus.iorq_n	= iorq_n;
	assign bus.rd_n		= rd_n;
	assign bus.wr_n		= wr_n;

	// ------------------------------------------------------------------
	// Slot and mapper registers
	// ------------------------------------------------------------------
	primary_slot u_primary_slot (
		.clk42m		(clk42m),	.ff_reset_n	(ff_reset_n),	.bus		(bus),
		.pslot_map	(),			.pslot_cur	(w_pslot_cur),	.page3_slot	(w_page3_slot),
		.rdata		(w_pslot_q),	.rdata_en	(w_pslot_q_en)
	);

	secondary_slot u_exp_slot0 (						// Slot 0-x, ROMs
		.clk42m		(clk42m),	.ff_reset_n	(ff_reset_n),	.bus		(bus),
		.own_slot	(2'd0),		.pslot_cur	(w_pslot_cur),	.page3_slot	(w_page3_slot),
		.sub_cur	(w_sub0),	.rdata		(w_exp0_q),		.rdata_en	(w_exp0_q_en)
	);

	secondary_slot u_exp_slot3 (						// Slot 3-x, RAM and ROMs
		.clk42m		(clk42m),	.ff_reset_n	(ff_reset_n),	.bus		(bus),
		.own_slot	(2'd3),		.pslot_cur	(w_pslot_cur),	.page3_slot	(w_page3_slot),
		.sub_cur	(w_sub3),	.rdata		(w_exp3_q),		.rdata_en	(w_exp3_q_en)
	);

	memory_mapper u_mapper (
		.clk42m		(clk42m),	.ff_reset_n	(ff_reset_n),	.bus		(bus),
		.segment	(w_segment),	.rdata		(w_mapper_q),	.rdata_en	(w_mapper_q_en)
	);

	sdram_address_map u_sdram_map (
		.bus			(bus),			.pslot_cur		(w_pslot_cur),
		.sub0			(w_sub0),		.sub3			(w_sub3),			.segment	(w_segment),
		.sdram_address	(sdram_address),	.sdram_mreq_n	(sdram_mreq_n),
		.sdram_rd_n		(sdram_rd_n),	.sdram_wr_n		(sdram_wr_n)
	);

	// ------------------------------------------------------------------
	// Read data mux register
	// ------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rdata <= 8'hFF;
		end
		else if (rd_n) begin
			ff_rdata <= 8'hFF;					// Idle bus floats high
		end
		else if (w_exp0_q_en) begin
			ff_rdata <= w_exp0_q;
		end
		else if (w_exp3_q_en) begin
			ff_rdata <= w_exp3_q;
		end
		else if (w_pslot_q_en) begin
			ff_rdata <= w_pslot_q;
		end
		else if (w_mapper_q_en) begin
			ff_rdata <= w_mapper_q;
		end
		// Nobody answers, keep FFh from the idle cycle
	end

	assign rdata = ff_rdata;

endmodule

`default_nettype wire

/* msx_bus_props.sv */
// Bus glue assertions
`default_nettype none

module msx_bus_props (
	input	wire			clk42m,
	input	wire			ff_reset_n,
	input	wire			mreq_n,
	input	wire			rd_n,
	input	wire			wr_n,
	input	wire	[7:0]	rdata,
	input	wire			sdram_rd_n,
	input	wire			sdram_wr_n
);
	int unsigned	fail_count = 0;		// Failed assertions so far

	// SDRAM write only under a CPU memory write
	a_wr_from_cpu: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!sdram_wr_n |-> (!wr_n && !mreq_n))
	else begin
		$error("sdram_wr_n low without a CPU memory write");
		fail_count++;
	end

	a_rd_wr_apart: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		!(!sdram_rd_n && !sdram_wr_n))
	else begin
		$error("sdram_rd_n and sdram_wr_n low together");
		fail_count++;
	end

	// Idle read bus returns FFh
	a_idle_rdata: assert property (@(posedge clk42m) disable iff (!ff_reset_n)
		rd_n |=> (rdata == 8'hFF))
	else begin
		$error("rdata not FFh after an idle cycle");
		fail_count++;
	end

endmodule

bind msx_bus_glue msx_bus_props u_props (
	.clk42m		(clk42m),		.ff_reset_n	(ff_reset_n),
	.mreq_n		(mreq_n),		.rd_n		(rd_n),			.wr_n	(wr_n),
	.rdata		(rdata),		.sdram_rd_n	(sdram_rd_n),	.sdram_wr_n	(sdram_wr_n)
);

`default_nettype wire

/* bus_checker.sv */
// Bus response checker
`default_nettype none

module bus_checker (
	input	wire			clk42m,
	input	wire			check_req,			// One cycle, last of an access
	input	wire	[7:0]	test_idx,
	input	wire	[3:0]	test_op,
	input	wire	[15:0]	test_addr,
	input	wire	[3:0]	check_mask,			// rdata, address, rd_n, wr_n
	input	wire	[7:0]	exp_rdata,
	input	wire	[22:0]	exp_sdram_address,
	input	wire			exp_sdram_rd_n,
	input	wire			exp_sdram_wr_n,
	input	wire	[7:0]	rdata,
	input	wire	[22:0]	sdram_address,
	input	wire			sdram_mreq_n,
	input	wire			sdram_rd_n,
	input	wire			sdram_wr_n,
	output	wire	[31:0]	checked_count,
	output	wire	[31:0]	error_count
);
	logic	[31:0]	n_checked = '0;
	logic	[31:0]	n_errors = '0;

	function automatic string op_name(input logic [3:0] op);
		case (op)
			4'h0:		return "mem_rd";
			4'h1:		return "mem_wr";
			4'h2:		return "io_rd";
			4'h3:		return "io_wr";
			default:	return "unknown";
		endcase
	endfunction

	// ------------------------------------------------------------------
	// Compare on the rising edge, rdata still holds the earlier load
	// ------------------------------------------------------------------
	always @(posedge clk42m) begin : compare
		string			name;
		logic	[31:0]	bad;
		logic			exp_mreq_n;
		if (check_req) begin
			name		= $sformatf("t%02d_%s_%04h", test_idx, op_name(test_op), test_addr);
			bad			= '0;
			exp_mreq_n	= !(test_op == 4'h0 || test_op == 4'h1);	// Memory ops only
			if (check_mask[0] && rdata !== exp_rdata) begin
				$display("MISMATCH %s rdata expected %02h actual %02h", name, exp_rdata, rdata);
				bad++;
			end
			if (check_mask[1] && sdram_address !== exp_sdram_address) begin
				$display("MISMATCH %s sdram_address expected %06h actual %06h",
					name, exp_sdram_address, sdram_address);
				bad++;
			end
			if (check_mask[2] && sdram_rd_n !== exp_sdram_rd_n) begin
				$display("MISMATCH %s sdram_rd_n expected %b actual %b",
					name, exp_sdram_rd_n, sdram_rd_n);
				bad++;
			end
			if (check_mask[3] && sdram_wr_n !== exp_sdram_wr_n) begin
				$display("MISMATCH %s sdram_wr_n expected %b actual %b",
					name, exp_sdram_wr_n, sdram_wr_n);
				bad++;
			end
			// Request strobe checked on every access
			if (sdram_mreq_n !== exp_mreq_n) begin
				$display("MISMATCH %s sdram_mreq_n expected %b actual %b",
					name, exp_mreq_n, sdram_mreq_n);
				bad++;
			end
			if (bad == 0) begin
				$display("test %s ok", name);
			end
			else begin
				$display("test %s failed with %0d mismatches", name, bad);
			end
			n_errors	<= n_errors + bad;
			n_checked	<= n_checked + 1;
		end
	end

	assign checked_count	= n_checked;
	assign error_count		= n_errors;

endmodule

`default_nettype wire

/* tb_msx_bus_glue.sv */
// MSX bus glue testbench
`default_nettype none

module tb_msx_bus_glue;

	localparam int			REC_WORDS		= 8;	// Tokens per access in the data file
	localparam int			MAX_RECS		= 64;
	localparam int			RESET_CYCLES	= 8;
	localparam int			HOLD_CYCLES		= 4;	// Strobes held per access
	localparam int			IDLE_CYCLES		= 2;
	localparam int			CHECK_TIMEOUT	= 16;
	localparam logic [3:0]	OP_MEM_RD		= 4'h0;
	localparam logic [3:0]	OP_MEM_WR		= 4'h1;
	localparam logic [3:0]	OP_IO_RD		= 4'h2;
	localparam logic [3:0]	OP_IO_WR		= 4'h3;
	localparam logic [3:0]	OP_END			= 4'hF;

	logic			clk42m;
	logic			ff_reset_n;
	logic	[15:0]	address;
	logic	[7:0]	wdata;
	logic			mreq_n;
	logic			iorq_n;
	logic			rd_n;
	logic			wr_n;
	wire	[7:0]	rdata;
	wire	[22:0]	sdram_address;
	wire			sdram_mreq_n;
	wire			sdram_rd_n;
	wire			sdram_wr_n;

	// Expected side, handed to the checker with each access
	logic			check_req;
	logic	[7:0]	test_idx;
	logic	[3:0]	test_op;
	logic	[3:0]	check_mask;
	logic	[7:0]	exp_rdata;
	logic	[22:0]	exp_sdram_address;
	logic			exp_sdram_rd_n;
	logic			exp_sdram_wr_n;
	wire	[31:0]	checked_count;
	wire	[31:0]	error_count;
	logic			timed_out;
	logic			bad_op;

	logic	[31:0]	vectors [0:REC_WORDS*MAX_RECS-1];

	msx_bus_glue dut_i (
		.clk42m			(clk42m),		.ff_reset_n		(ff_reset_n),
		.address		(address),		.wdata			(wdata),
		.mreq_n			(mreq_n),		.iorq_n			(iorq_n),
		.rd_n			(rd_n),			.wr_n			(wr_n),
		.rdata			(rdata),		.sdram_address	(sdram_address),
		.sdram_mreq_n	(sdram_mreq_n),	.sdram_rd_n		(sdram_rd_n),
		.sdram_wr_n		(sdram_wr_n)
	);

	bus_checker u_checker (
		.clk42m				(clk42m),			.check_req		(check_req),
		.test_idx			(test_idx),			.test_op		(test_op),
		.test_addr			(address),			.check_mask		(check_mask),
		.exp_rdata			(exp_rdata),		.exp_sdram_address	(exp_sdram_address),
		.exp_sdram_rd_n		(exp_sdram_rd_n),	.exp_sdram_wr_n	(exp_sdram_wr_n),
		.rdata				(rdata),			.sdram_address	(sdram_address),
		.sdram_mreq_n		(sdram_mreq_n),
		.sdram_rd_n			(sdram_rd_n),		.sdram_wr_n		(sdram_wr_n),
		.checked_count		(checked_count),	.error_count	(error_count)
	);

	always #5 clk42m = ~clk42m;					// 10 unit period

	// ------------------------------------------------------------------
	// Bus tasks, called at a falling edge
	// ------------------------------------------------------------------
	task automatic release_bus();
		address		= 16'h0000;
		wdata		= 8'h00;
		mreq_n		= 1'b1;
		iorq_n		= 1'b1;
		rd_n		= 1'b1;
		wr_n		= 1'b1;
		check_req	= 1'b0;
	endtask

	task automatic run_access(input int rec);
		int				base;
		logic	[3:0]	op;
		logic	[31:0]	count_before;
		int				waited;
		base				= rec * REC_WORDS;
		op					= vectors[base][3:0];
		count_before		= checked_count;
		test_idx			= rec[7:0];
		test_op				= op;
		check_mask			= vectors[base + 1][3:0];
		exp_rdata			= vectors[base + 4][7:0];
		exp_sdram_address	= vectors[base + 5][22:0];
		exp_sdram_rd_n		= vectors[base + 6][0];
		exp_sdram_wr_n		= vectors[base + 7][0];
		address				= vectors[base + 2][15:0];
		wdata				= vectors[base + 3][7:0];
		mreq_n				= !(op == OP_MEM_RD || op == OP_MEM_WR);
		iorq_n				= !(op == OP_IO_RD || op == OP_IO_WR);
		rd_n				= !(op == OP_MEM_RD || op == OP_IO_RD);
		wr_n				= !(op == OP_MEM_WR || op == OP_IO_WR);
		for (int i = 1; i < HOLD_CYCLES; i++) begin
			@(negedge clk42m);
		end
		check_req	= 1'b1;						// Sampled on the last rising edge
		waited		= 0;
		while (checked_count == count_before && waited < CHECK_TIMEOUT) begin
			@(negedge clk42m);
			waited++;
		end
		if (checked_count == count_before) begin
			$display("timeout: checker gave no result for record %0d", rec);
			timed_out = 1'b1;
		end
		release_bus();
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			@(negedge clk42m);
		end
	endtask

	// ------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------
	initial begin : main
		int				rec;
		logic	[3:0]	op;
		logic			stop;
		clk42m		= 1'b0;
		ff_reset_n	= 1'b0;
		timed_out	= 1'b0;
		bad_op		= 1'b0;
		test_idx	= 8'd0;
		test_op		= OP_END;
		check_mask	= 4'h0;
		exp_rdata	= 8'hFF;
		exp_sdram_address	= 23'd0;
		exp_sdram_rd_n		= 1'b1;
		exp_sdram_wr_n		= 1'b1;
		release_bus();
		$readmemh("msx_testdata.txt", vectors);
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(negedge clk42m);
		end
		ff_reset_n	= 1'b1;
		@(negedge clk42m);
		rec		= 0;
		stop	= 1'b0;
		while (!stop && rec < MAX_RECS) begin
			op = vectors[rec * REC_WORDS][3:0];
			if (op == OP_END || $isunknown(op)) begin
				stop = 1'b1;					// End marker
			end
			else if (op > OP_IO_WR) begin
				$display("unknown operation code %h in record %0d", op, rec);
				bad_op	= 1'b1;
				stop	= 1'b1;
			end
			else begin
				run_access(rec);
				stop	= timed_out;
				rec++;
			end
		end
		if (checked_count == 0) begin
			$display("no test records were run");
		end
		$display("%0d tests, %0d mismatches, %0d assertion failures",
			checked_count, error_count, dut_i.u_props.fail_count);
		if (!timed_out && !bad_op && checked_count != 0 && error_count == 0 &&
			dut_i.u_props.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end
		else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* msx_testdata.txt */
// op flags address wdata exp_rdata exp_sdram_address exp_sdram_rd_n exp_sdram_wr_n
// op 0 mem rd, 1 mem wr, 2 io rd, 3 io wr, F end; flags b0 rdata b1 addr b2 rd_n b3 wr_n
// Reset values
2 D 00A8 00 00 000000 1 1
2 D 00FC 00 03 000000 1 1
2 D 00FD 00 02 000000 1 1
2 D 00FE 00 01 000000 1 1
2 D 00FF 00 00 000000 1 1
0 F 1234 00 FF 021234 0 1
// Primary slot, page 0 to slot 3-0 then empty slot 1
3 C 00A8 03 00 000000 1 1
2 D 00A8 00 03 000000 1 1
0 F 0010 00 FF 40C010 0 1
// Secondary slot 0, BASIC'N on page 1
3 C 00A8 00 00 000000 1 1
1 C FFFF 04 00 000000 1 1
0 1 FFFF 00 FB 000000 1 1
0 F 4123 00 FF 030123 0 1
// Secondary slot 3, kanji BASIC on page 2
3 C 00A8 C0 00 000000 1 1
1 E FFFF 10 00 403FFF 1 0
0 1 FFFF 00 EF 000000 1 1
3 C 00A8 F0 00 000000 1 1
0 F 8123 00 FF 02C123 0 1
// Mapper RAM on page 1
3 C 00FD 5A 00 000000 1 1
2 D 00FD 00 5A 000000 1 1
3 C 00A8 FC 00 000000 1 1
0 F 4567 00 FF 568567 0 1
1 E 4567 33 00 568567 1 0
// Empty slots, unmapped page, unselected ports
3 C 00A8 05 00 000000 1 1
0 D 0000 00 FF 000000 1 1
1 C 4000 77 00 000000 1 1
0 D 8000 00 FF 000000 1 1
0 1 FFFF 00 FB 000000 1 1
2 D 0098 00 FF 000000 1 1
2 D 00A9 00 FF 000000 1 1
F 0 0000 00 00 000000 0 0

/* verilog.f */
+incdir+.
msx_pkg.sv
cpu_bus_if.sv
primary_slot.sv
secondary_slot.sv
memory_mapper.sv
sdram_address_map.sv
msx_bus_glue.sv
msx_bus_props.sv
bus_checker.sv
tb_msx_bus_glue.sv

/* Makefile */
# Verilator build and run of the MSX bus glue testbench

VERILATOR	?= verilator
TOP			?= tb_msx_bus_glue
FILELIST	?= verilog.f
BUILD_DIR	?= obj_dir
VFLAGS		?= --binary --timing --assert
RUN_ARGS	?= +verilator+error+limit+100
PASS_TEXT	?= ALL CHECKS PASSED
SIM			:= $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
